//--- design/motion_pkg.sv
`default_nettype none

package motion_pkg;

  // One colour channel of the RGB555 input
  typedef logic [4:0] chan_t;

  // Output channel for the video DAC side
  typedef logic [9:0] vga_chan_t;

  // Raster coordinate
  typedef logic [9:0] coord_t;

  // Input pixel, top bit unused
  typedef struct packed {
    logic  pad;        // Spare bit
    chan_t r;          // Red
    chan_t g;          // Green
    chan_t b;          // Blue
  } rgb555_t;

  // Vertical window depth, current line plus ten stored lines
  localparam int NUM_TAPS = 11;

  // Brightness cut on r+g+b, 7-bit sum
  localparam logic [6:0] LUMA_THRESHOLD = 7'd48;

  // Reduction applied over the taps
  typedef enum logic {
    MORPH_ERODE  = 1'b0,  // AND of all taps
    MORPH_DILATE = 1'b1   // OR of all taps
  } morph_op_e;

endpackage

`default_nettype wire

//--- design/motion_pix_if.sv
`timescale 1ns/1ps
`default_nettype none

interface motion_pix_if
  import motion_pkg::*;
();

  logic    valid;   // One strobe per pixel, no back-pressure
  coord_t  x;       // Column of this pixel
  coord_t  y;       // Line of this pixel
  rgb555_t pix;     // Current-frame pixel
  logic    bit_a;   // Method 1 path
  logic    bit_b;   // Method 2 path

  // Producing stage
  modport src (
    output valid,
    output x,
    output y,
    output pix,
    output bit_a,
    output bit_b
  );

  // Consuming stage
  modport dst (
    input valid,
    input x,
    input y,
    input pix,
    input bit_a,
    input bit_b
  );

endinterface

`default_nettype wire

//--- design/pixel_binarize.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_binarize
  import motion_pkg::*;
#(
  parameter int LINE_LEN    = 640,
  parameter int FRAME_LINES = 480
) (
  input  logic      iCLK_50,
  input  logic      rst_n,
  input  logic      pix_valid,
  input  rgb555_t   cur_pixel,
  input  rgb555_t   prev_pixel,
  motion_pix_if.src bin
);

  logic    acc_valid;  // Input stage holds a pixel
  coord_t  x_cnt;      // Raster column of next pixel
  coord_t  y_cnt;      // Raster line of next pixel
  rgb555_t cur_q;      // Captured current pixel
  rgb555_t prev_q;     // Captured previous-frame pixel
  coord_t  x_q;
  coord_t  y_q;

  // Bright when the channel sum is above the threshold
  function automatic logic is_bright(input rgb555_t p);
    logic [6:0] sum;
    sum = 7'(p.r) + 7'(p.g) + 7'(p.b);
    return sum > LUMA_THRESHOLD;
  endfunction

  // Input stage control and raster counter
  always_ff @(posedge iCLK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_valid <= 1'b0;
      x_cnt     <= '0;
      y_cnt     <= '0;
    end
    else
    begin
      acc_valid <= pix_valid;
      if (pix_valid)
      begin
        if (x_cnt == coord_t'(LINE_LEN - 1))  // End of line
        begin
          x_cnt <= '0;
          y_cnt <= (y_cnt == coord_t'(FRAME_LINES - 1)) ? '0 : y_cnt + 1'b1;
        end
        else
          x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  // Input stage payload
  always_ff @(posedge iCLK_50)
  begin
    if (pix_valid)
    begin
      cur_q  <= cur_pixel;
      prev_q <= prev_pixel;
      x_q    <= x_cnt;   // Coordinate stamped before the counter moves
      y_q    <= y_cnt;
    end
  end

  always_ff @(posedge iCLK_50 or negedge rst_n)
  begin
    if (!rst_n)
      bin.valid <= 1'b0;
    else
      bin.valid <= acc_valid;
  end

  // Difference bits, registered with the pixel
  always_ff @(posedge iCLK_50)
  begin
    if (acc_valid)
    begin
      bin.x     <= x_q;
      bin.y     <= y_q;
      bin.pix   <= cur_q;
      bin.bit_a <= (cur_q.r != prev_q.r) || (cur_q.g != prev_q.g)
                   || (cur_q.b != prev_q.b);               // Any channel changed
      bin.bit_b <= is_bright(cur_q) ^ is_bright(prev_q);   // Crossed the threshold
    end
  end

endmodule

`default_nettype wire

//--- design/line_window.sv
`timescale 1ns/1ps
`default_nettype none

module line_window
  import motion_pkg::*;
#(
  parameter int        LINE_LEN = 640,
  parameter morph_op_e OP       = MORPH_ERODE
) (
  input  logic      iCLK_50,
  input  logic      rst_n,
  motion_pix_if.dst in_line,
  motion_pix_if.src out_line
);

  localparam int COL_W = $clog2(LINE_LEN);

  // Only the erode stage works on the method 2 bit, dilate passes it on
  localparam bit REDUCE_B = (OP == MORPH_ERODE);

  logic [NUM_TAPS-2:0] hist_a [LINE_LEN];  // Ten earlier lines per column
  logic [NUM_TAPS-2:0] hist_b [LINE_LEN];
  logic [COL_W-1:0]    col;                // Column index into history
  logic [NUM_TAPS-1:0] taps_a;             // Stored bits plus incoming bit
  logic [NUM_TAPS-1:0] taps_b;

  function automatic logic reduce_taps(input logic [NUM_TAPS-1:0] taps);
    return (OP == MORPH_ERODE) ? &taps : |taps;
  endfunction

  assign col    = in_line.x[COL_W-1:0];
  assign taps_a = {hist_a[col], in_line.bit_a};  // Newest tap at bit 0
  assign taps_b = {hist_b[col], in_line.bit_b};

  // Strobe and line history
  always_ff @(posedge iCLK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_line.valid <= 1'b0;
      for (int i = 0; i < LINE_LEN; i++)
      begin
        hist_a[i] <= '0;
        hist_b[i] <= '0;
      end
    end
    else
    begin
      out_line.valid <= in_line.valid;
      if (in_line.valid)  // History moves only on real pixels
      begin
        hist_a[col] <= taps_a[NUM_TAPS-2:0];  // Oldest line drops out
        hist_b[col] <= taps_b[NUM_TAPS-2:0];
      end
    end
  end

  // Pixel payload and reduced bits, one cycle
  always_ff @(posedge iCLK_50)
  begin
    if (in_line.valid)
    begin
      out_line.x     <= in_line.x;
      out_line.y     <= in_line.y;
      out_line.pix   <= in_line.pix;
      out_line.bit_a <= reduce_taps(taps_a);
      out_line.bit_b <= REDUCE_B ? reduce_taps(taps_b) : in_line.bit_b;
    end
  end

endmodule

`default_nettype wire

//--- design/motion_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module motion_overlay
  import motion_pkg::*;
#(
  parameter int LINE_LEN    = 640,
  parameter int FRAME_LINES = 480,
  parameter int WIN_X_LO    = 20,
  parameter int WIN_X_HI    = 620,
  parameter int WIN_Y_LO    = 20,
  parameter int WIN_Y_HI    = 460
) (
  input  logic      iCLK_50,
  input  logic      rst_n,
  motion_pix_if.dst stage,
  output logic      out_valid,
  output vga_chan_t out_r,
  output vga_chan_t out_g,
  output vga_chan_t out_b,
  output logic      motion
);

  // Window upper bounds clipped to the frame
  localparam int X_END = (WIN_X_HI < LINE_LEN) ? WIN_X_HI : LINE_LEN;
  localparam int Y_END = (WIN_Y_HI < FRAME_LINES) ? WIN_Y_HI : FRAME_LINES;

  logic      in_win;   // Pixel lies in the paint window
  logic      hit;      // Either method flags this pixel
  vga_chan_t r_plain;  // Channels expanded to 10 bits
  vga_chan_t g_plain;
  vga_chan_t b_plain;

  assign in_win = (stage.x >= coord_t'(WIN_X_LO)) && (stage.x < coord_t'(X_END))
                  && (stage.y >= coord_t'(WIN_Y_LO)) && (stage.y < coord_t'(Y_END));

  // Method 2 bit rode through the dilate stage with its pixel, so it is aligned here
  assign hit = stage.bit_a | stage.bit_b;

  assign r_plain = {stage.pix.r, 5'b0};  // Channel to the top, zeros below
  assign g_plain = {stage.pix.g, 5'b0};
  assign b_plain = {stage.pix.b, 5'b0};

  always_ff @(posedge iCLK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      motion    <= 1'b0;
    end
    else
    begin
      out_valid <= stage.valid;
      motion    <= stage.valid & hit;  // Flag only pulses with a pixel
    end
  end

  // Red overlay inside the window
  always_ff @(posedge iCLK_50)
  begin
    if (stage.valid)
    begin
      out_r <= (in_win && hit) ? vga_chan_t'(1023) : r_plain;
      out_g <= g_plain;
      out_b <= b_plain;
    end
  end

endmodule

`default_nettype wire

//--- design/motion_alarm.sv
`timescale 1ns/1ps
`default_nettype none

module motion_alarm #(
  parameter int HOLD_CYCLES = 2**24 - 1,
  parameter int TONE_BIT    = 21
) (
  input  logic iCLK_50,
  input  logic rst_n,
  input  logic motion,
  output logic alarm,
  output logic speaker
);

  localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);

  localparam logic [HOLD_W-1:0] HOLD_MAX = HOLD_W'(HOLD_CYCLES);

  logic [HOLD_W-1:0] hold_cnt;  // Cycles since last detection
  logic [TONE_BIT:0] tone_cnt;  // Free-running tone divider

  // Hold timer, parks at its limit when idle
  always_ff @(posedge iCLK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hold_cnt <= HOLD_MAX;  // Alarm off out of reset
      alarm    <= 1'b0;
    end
    else
    begin
      alarm <= motion || (hold_cnt < HOLD_MAX);
      if (motion)
        hold_cnt <= '0;  // Restart hold
      else if (hold_cnt < HOLD_MAX)
        hold_cnt <= hold_cnt + 1'b1;
    end
  end

  always_ff @(posedge iCLK_50 or negedge rst_n)
  begin
    if (!rst_n)
      tone_cnt <= '0;
    else
      tone_cnt <= tone_cnt + 1'b1;
  end

  // Square wave only while the alarm holds
  assign speaker = alarm & tone_cnt[TONE_BIT];

endmodule

`default_nettype wire

//--- design/motion_detect_top.sv
`timescale 1ns/1ps
`default_nettype none

module motion_detect_top
  import motion_pkg::*;
#(
  parameter int LINE_LEN    = 640,
  parameter int FRAME_LINES = 480,
  parameter int WIN_X_LO    = 20,
  parameter int WIN_X_HI    = 620,
  parameter int WIN_Y_LO    = 20,
  parameter int WIN_Y_HI    = 460,
  parameter int HOLD_CYCLES = 2**24 - 1,
  parameter int TONE_BIT    = 21
) (
  input  logic      iCLK_50,
  input  logic      rst_n,
  input  logic      pix_valid,   // Pixel pair strobe
  input  rgb555_t   cur_pixel,   // Live frame
  input  rgb555_t   prev_pixel,  // Stored frame
  output logic      out_valid,
  output vga_chan_t out_r,
  output vga_chan_t out_g,
  output vga_chan_t out_b,
  output logic      motion,
  output logic      alarm,
  output logic      speaker
);

  motion_pix_if bin_if ();  // Binarize to erode
  motion_pix_if ero_if ();  // Erode to dilate
  motion_pix_if dil_if ();  // Dilate to overlay

  pixel_binarize #(
    .LINE_LEN    (LINE_LEN),
    .FRAME_LINES (FRAME_LINES)
  ) binarize_i (
    .iCLK_50    (iCLK_50),
    .rst_n      (rst_n),
    .pix_valid  (pix_valid),
    .cur_pixel  (cur_pixel),
    .prev_pixel (prev_pixel),
    .bin        (bin_if.src)
  );

  // Erode both methods
  line_window #(
    .LINE_LEN (LINE_LEN),
    .OP       (MORPH_ERODE)
  ) erode_i (
    .iCLK_50  (iCLK_50),
    .rst_n    (rst_n),
    .in_line  (bin_if.dst),
    .out_line (ero_if.src)
  );

  // Dilate method 1 only
  line_window #(
    .LINE_LEN (LINE_LEN),
    .OP       (MORPH_DILATE)
  ) dilate_i (
    .iCLK_50  (iCLK_50),
    .rst_n    (rst_n),
    .in_line  (ero_if.dst),
    .out_line (dil_if.src)
  );

  motion_overlay #(
    .LINE_LEN    (LINE_LEN),
    .FRAME_LINES (FRAME_LINES),
    .WIN_X_LO    (WIN_X_LO),
    .WIN_X_HI    (WIN_X_HI),
    .WIN_Y_LO    (WIN_Y_LO),
    .WIN_Y_HI    (WIN_Y_HI)
  ) overlay_i (
    .iCLK_50   (iCLK_50),
    .rst_n     (rst_n),
    .stage     (dil_if.dst),
    .out_valid (out_valid),
    .out_r     (out_r),
    .out_g     (out_g),
    .out_b     (out_b),
    .motion    (motion)
  );

  motion_alarm #(
    .HOLD_CYCLES (HOLD_CYCLES),
    .TONE_BIT    (TONE_BIT)
  ) alarm_i (
    .iCLK_50 (iCLK_50),
    .rst_n   (rst_n),
    .motion  (motion),
    .alarm   (alarm),
    .speaker (speaker)
  );

endmodule

`default_nettype wire

//--- test/motion_detect_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module motion_detect_asserts (
  input logic iCLK_50,
  input logic rst_n,
  input logic pix_valid,
  input logic out_valid,
  input logic motion,
  input logic alarm
);

  logic [4:0] pv_hist;       // pix_valid seen at the last five edges
  int         fail_cnt = 0;  // Read by the testbench at the end

  always_ff @(posedge iCLK_50 or negedge rst_n)
  begin
    if (!rst_n)
      pv_hist <= '0;
    else
      pv_hist <= {pv_hist[3:0], pix_valid};
  end

  // Outputs only move on the rising edge, so the falling edge sees them settled
  property valid_latency;
    @(negedge iCLK_50) disable iff (!rst_n)
      out_valid == pv_hist[4];  // Four-stage pipeline
  endproperty

  property quiet_in_reset;
    @(negedge iCLK_50) !rst_n |-> (!out_valid && !motion && !alarm);
  endproperty

  property alarm_follows_motion;
    @(negedge iCLK_50) disable iff (!rst_n)
      motion |=> alarm;  // One register behind motion
  endproperty

  valid_latency_a : assert property (valid_latency)
  else
  begin
    $error("out_valid does not trail pix_valid by four cycles");
    fail_cnt++;
  end

  quiet_in_reset_a : assert property (quiet_in_reset)
  else
  begin
    $error("outputs active during reset");
    fail_cnt++;
  end

  alarm_follows_motion_a : assert property (alarm_follows_motion)
  else
  begin
    $error("alarm did not rise the cycle after motion");
    fail_cnt++;
  end

endmodule

bind motion_detect_top motion_detect_asserts asserts_i (
  .iCLK_50   (iCLK_50),
  .rst_n     (rst_n),
  .pix_valid (pix_valid),
  .out_valid (out_valid),
  .motion    (motion),
  .alarm     (alarm)
);

`default_nettype wire

//--- test/motion_detect_tb.sv
`timescale 1ns/1ps
`default_nettype none

module motion_detect_tb
  import motion_pkg::*;
();

  localparam int LINE_LEN    = 32;
  localparam int FRAME_LINES = 48;
  localparam int FRAME_PIX   = LINE_LEN * FRAME_LINES;
  localparam int WIN_X_LO    = 2;
  localparam int WIN_X_HI    = 28;
  localparam int WIN_Y_LO    = 12;
  localparam int WIN_Y_HI    = 40;
  localparam int HOLD_CYCLES = 200;
  localparam int TONE_BIT    = 3;
  localparam int BRIGHT_CUT  = 48;  // Sum above this is bright
  localparam int DEPTH       = 10;  // Stored lines per column
  localparam int RAND_PIX    = 1000;
  localparam int TOTAL_PIX   = 6 * FRAME_PIX + 16 * LINE_LEN + RAND_PIX;
  localparam int CYCLE_LIMIT = TOTAL_PIX * 3 + 500;

  typedef struct packed {
    logic [9:0] r;
    logic [9:0] g;
    logic [9:0] b;
  } exp_pix_t;

  logic      iCLK_50 = 1'b0;
  logic      rst_n;
  logic      pix_valid;
  rgb555_t   cur_pixel;
  rgb555_t   prev_pixel;
  logic      out_valid;
  vga_chan_t out_r;
  vga_chan_t out_g;
  vga_chan_t out_b;
  logic      motion;
  logic      alarm;
  logic      speaker;

  bit                h_a [LINE_LEN][DEPTH];  // Diff bit history
  bit                h_b [LINE_LEN][DEPTH];  // Brightness bit history
  bit                h_e [LINE_LEN][DEPTH];  // Eroded diff bit history
  int                mx = 0;                 // Model raster column
  int                my = 0;
  exp_pix_t          exp_q [$];              // Colours still in flight
  exp_pix_t          head;
  logic [3:0]        v_pipe;
  logic [3:0]        m_pipe;
  logic [1:0]        b_pipe;                 // Brightness flag up to the binarize output
  logic              exp_valid;
  logic              exp_motion;
  logic              step_mot;
  logic              step_bb;
  logic              alarm_m;
  int                hold_m;
  logic [TONE_BIT:0] tone_m;                 // Mirror of the tone divider
  int                errors = 0;
  int                checks = 0;
  int                tests = 0;
  int                test_err0 = 0;
  int                cycles = 0;

  motion_detect_top #(
    .LINE_LEN    (LINE_LEN),
    .FRAME_LINES (FRAME_LINES),
    .WIN_X_LO    (WIN_X_LO),
    .WIN_X_HI    (WIN_X_HI),
    .WIN_Y_LO    (WIN_Y_LO),
    .WIN_Y_HI    (WIN_Y_HI),
    .HOLD_CYCLES (HOLD_CYCLES),
    .TONE_BIT    (TONE_BIT)
  ) dut_i (
    .iCLK_50    (iCLK_50),
    .rst_n      (rst_n),
    .pix_valid  (pix_valid),
    .cur_pixel  (cur_pixel),
    .prev_pixel (prev_pixel),
    .out_valid  (out_valid),
    .out_r      (out_r),
    .out_g      (out_g),
    .out_b      (out_b),
    .motion     (motion),
    .alarm      (alarm),
    .speaker    (speaker)
  );

  always #4 iCLK_50 = ~iCLK_50;  // 8 ns period

  // Reference for one accepted pixel, returns its motion flag
  function automatic logic model_pixel(input rgb555_t cur, input rgb555_t prev);
    logic     ba;
    logic     bb;
    logic     ea;
    logic     eb;
    logic     da;
    int       s_cur;
    int       s_prev;
    int       k;
    exp_pix_t e;
    ba     = (cur.r != prev.r) || (cur.g != prev.g) || (cur.b != prev.b);
    s_cur  = int'(cur.r) + int'(cur.g) + int'(cur.b);
    s_prev = int'(prev.r) + int'(prev.g) + int'(prev.b);
    bb     = (s_cur > BRIGHT_CUT) != (s_prev > BRIGHT_CUT);
    step_bb = bb;  // Raw threshold flag of this pixel
    ea     = ba;
    eb     = bb;
    for (k = 0; k < DEPTH; k++)
    begin
      ea = ea & h_a[mx][k];  // Erode needs all eleven lines
      eb = eb & h_b[mx][k];
    end
    da = ea;
    for (k = 0; k < DEPTH; k++)
      da = da | h_e[mx][k];  // Dilate over eroded lines
    for (k = DEPTH - 1; k > 0; k--)
    begin
      h_a[mx][k] = h_a[mx][k-1];
      h_b[mx][k] = h_b[mx][k-1];
      h_e[mx][k] = h_e[mx][k-1];
    end
    h_a[mx][0] = ba;
    h_b[mx][0] = bb;
    h_e[mx][0] = ea;
    e.g = {cur.g, 5'b0};
    e.b = {cur.b, 5'b0};
    if ((da || eb) && mx >= WIN_X_LO && mx < WIN_X_HI && my >= WIN_Y_LO && my < WIN_Y_HI)
      e.r = 10'd1023;  // Painted red
    else
      e.r = {cur.r, 5'b0};
    exp_q.push_back(e);
    if (mx == LINE_LEN - 1)
    begin
      mx = 0;
      my = (my == FRAME_LINES - 1) ? 0 : my + 1;
    end
    else
      mx = mx + 1;
    return da || eb;
  endfunction

  // Cycle model of strobe, motion, alarm and tone
  always @(posedge iCLK_50 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      v_pipe     <= '0;
      m_pipe     <= '0;
      b_pipe     <= '0;
      exp_valid  <= 1'b0;
      exp_motion <= 1'b0;
      alarm_m    <= 1'b0;
      hold_m     <= HOLD_CYCLES;  // Idle, alarm off
      tone_m     <= '0;
    end
    else
    begin
      if (pix_valid)
        step_mot = model_pixel(cur_pixel, prev_pixel);
      else
      begin
        step_mot = 1'b0;
        step_bb  = 1'b0;
      end
      v_pipe     <= {v_pipe[2:0], pix_valid};
      m_pipe     <= {m_pipe[2:0], step_mot};
      b_pipe     <= {b_pipe[0], step_bb};
      exp_valid  <= v_pipe[3];
      exp_motion <= m_pipe[3];
      alarm_m    <= exp_motion || (hold_m < HOLD_CYCLES);
      if (exp_motion)
        hold_m <= 0;
      else if (hold_m < HOLD_CYCLES)
        hold_m <= hold_m + 1;
      tone_m <= tone_m + 1'b1;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want)
    else
    begin
      $display("FAIL %s got %h exp %h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1)
    else
    begin
      $display("%s", what);
      errors++;
    end
  endtask

  // Outputs settle mid-cycle
  always @(negedge iCLK_50)
  begin
    if (rst_n)
    begin
      check_val("out_valid", out_valid, exp_valid);
      check_val("motion", motion, exp_motion);
      check_val("alarm", alarm, alarm_m);
      check_val("speaker", speaker, alarm_m & tone_m[TONE_BIT]);
      if (v_pipe[1])
        check_val("bit_b", dut_i.bin_if.bit_b, b_pipe[1]);  // Threshold flag one stage in
      if (out_valid)
      begin
        if (exp_q.size() == 0)
          check_true(1'b0, "an output pixel appeared with none expected");
        else
        begin
          head = exp_q.pop_front();
          check_val("out_r", out_r, head.r);
          check_val("out_g", out_g, head.g);
          check_val("out_b", out_b, head.b);
        end
      end
    end
  end

  always @(posedge iCLK_50)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic put_pixel(input logic v, input rgb555_t cur, input rgb555_t prev);
    @(negedge iCLK_50);
    pix_valid  = v;
    cur_pixel  = cur;
    prev_pixel = prev;
  endtask

  task automatic idle(input int n);
    repeat (n) put_pixel(1'b0, '0, '0);
  endtask

  function automatic rgb555_t rand_pix();
    return rgb555_t'({1'b0, 15'($urandom)});
  endfunction

  function automatic rgb555_t differ_from(input rgb555_t p);
    rgb555_t q;
    q = rand_pix();
    if (q == p)
      q.r = ~p.r;  // Force at least one channel apart
    return q;
  endfunction

  task automatic end_test(input string name);
    idle(8);  // Drain the pipeline
    check_true(exp_q.size() == 0, "expected output pixels never appeared");
    tests++;
    $display("Test %0d %s done, %0d errors", tests, name, errors - test_err0);
    test_err0 = errors;
  endtask

  initial
  begin
    int      n;
    int      x;
    int      y;
    int      total;
    rgb555_t a;
    rgb555_t q;
    void'($urandom(60));
    rst_n      = 1'b0;
    pix_valid  = 1'b0;
    cur_pixel  = '0;
    prev_pixel = '0;
    repeat (3) @(posedge iCLK_50);
    @(negedge iCLK_50);
    rst_n = 1'b1;

    for (n = 0; n < 3 * FRAME_PIX; n++)
    begin
      a = rand_pix();
      put_pixel(1'b1, a, a);  // Nothing moves
    end
    end_test("still scene");

    for (n = 0; n < FRAME_PIX; n++)
    begin
      x = n % LINE_LEN;
      y = n / LINE_LEN;
      a = rand_pix();
      q = (x >= 6 && x < 20 && y >= 14 && y < 32) ? differ_from(a) : a;
      put_pixel(1'b1, q, a);
    end
    end_test("method 1 block");

    for (n = 0; n < FRAME_PIX; n++)
    begin
      x = n % LINE_LEN;
      y = n / LINE_LEN;
      a = rand_pix();
      q = a;
      if (x >= 4 && x < 24 && y >= 14 && y < 34)
      begin
        a.g = 5'(10 + $urandom % 6);
        q.g = a.g;  // Green kept equal
        if ($urandom % 4 != 0)
        begin
          a.r = 5'(20 + $urandom % 12);  // Sum at least 50
          a.b = 5'(20 + $urandom % 12);
          q.r = 5'($urandom % 8);        // Sum at most 29
          q.b = 5'($urandom % 8);
        end
        else
        begin
          a = rgb555_t'({1'b0, 5'd16, 5'd16, 5'd16});  // Sum 48, not bright
          q = rgb555_t'({1'b0, 5'd17, 5'd16, 5'd16});  // Sum 49, just bright
        end
      end
      if ($urandom % 2)
        put_pixel(1'b1, a, q);
      else
        put_pixel(1'b1, q, a);
    end
    end_test("method 2 brightness");

    for (n = 0; n < FRAME_PIX; n++)
    begin
      x = n % LINE_LEN;
      y = n / LINE_LEN;
      a = rand_pix();
      q = (x >= 24 && y < 20) ? differ_from(a) : a;  // Straddles two window edges
      put_pixel(1'b1, q, a);
    end
    end_test("window edge");

    for (n = 0; n < 16 * LINE_LEN; n++)
    begin
      a = rand_pix();
      put_pixel(1'b1, differ_from(a), a);
    end
    idle(20);
    check_true(alarm, "alarm dropped right after motion");
    idle(HOLD_CYCLES);
    check_true(!alarm, "alarm still on after the hold time");
    end_test("alarm hold and tone");

    n = 0;
    while (n < RAND_PIX)
    begin
      a = rand_pix();
      q = ($urandom % 8 != 0) ? differ_from(a) : a;
      if ($urandom % 5 < 3)
      begin
        put_pixel(1'b1, q, a);
        n++;
      end
      else
        put_pixel(1'b0, q, a);  // Junk while idle
    end
    end_test("random gaps");

    total = errors + dut_i.asserts_i.fail_cnt;
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, total);
    if (total == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- motion_detect_top.f
design/motion_pkg.sv
design/motion_pix_if.sv
design/pixel_binarize.sv
design/line_window.sv
design/motion_overlay.sv
design/motion_alarm.sv
design/motion_detect_top.sv
test/motion_detect_asserts.sv
test/motion_detect_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the motion detect testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f motion_detect_top.f --top-module motion_detect_tb -o motion_detect_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/motion_detect_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
exit 0
